/* verilog/fp_params.svh */
/*
 * Integer to float32 converter parameters
 * Operand width, float field widths, exponent bias and zero-count width
 */
`ifndef FP_PARAMS_SVH
`define FP_PARAMS_SVH

// Width of the signed integer operand
`define I2F_INT_W 32

// Stored mantissa bits of a single-precision value, hidden one excluded
`define I2F_MANT_W 23

// Biased exponent field width
`define I2F_EXP_W 8
`define I2F_EXP_BIAS 127

// Zero counts over the operand range 0..31 fit in five bits
`define I2F_CNT_W 5

`endif

/* verilog/lzc_pkg.sv */
/*
 * Zero counter package
 * Selects whether the counter looks from the LSB or from the MSB
 */
package lzc_pkg;

  typedef enum logic {
    TRAILING_ZERO_CNT = 1'b0,
    LEADING_ZERO_CNT  = 1'b1
  } lzc_mode_e;

endpackage

/* verilog/fp_pkg.sv */
/*
 * Float32 conversion package
 * IEEE single-precision layout and the payloads passed between pipeline stages
 */
`include "fp_params.svh"

package fp_pkg;

  // Field order matches the IEEE 754 bit layout, so the struct packs to the
  // raw 32-bit encoding with the sign in bit 31
  typedef struct packed {
    logic                   sign;
    logic [`I2F_EXP_W-1:0]  exponent;
    logic [`I2F_MANT_W-1:0] mantissa;
  } fp32_t;

  // Result of the front stage
  typedef struct packed {
    // Sign of the original operand
    logic                  sign;
    // Unsigned magnitude, the most negative operand maps to 2^31
    logic [`I2F_INT_W-1:0] magnitude;
    // Leading zeros of the magnitude, gives the normalization shift
    logic [`I2F_CNT_W-1:0] lead_cnt;
    // Trailing zeros of the magnitude, tells where the lowest one sits
    logic [`I2F_CNT_W-1:0] trail_cnt;
    // Magnitude has no set bit at all
    logic                  zero;
  } scan_t;

  // Result of the back stage as it leaves the pipeline
  typedef struct packed {
    fp32_t result;
    // At least one set bit was truncated away
    logic  inexact;
  } pack_t;

endpackage

/* verilog/lzc.sv */
/*
 * Leading or trailing zero counter
 * Binary select tree finds the first set bit, empty flag when there is none
 */
`timescale 1ns/1ps

module lzc import lzc_pkg::*; #(
  // Width of the vector to scan, at least two bits
  parameter int unsigned WIDTH     = 32,
  // Count from the LSB or from the MSB
  parameter lzc_mode_e   MODE      = TRAILING_ZERO_CNT,
  // Width of the count output, normally the log2 of WIDTH
  parameter int unsigned CNT_WIDTH = $clog2(WIDTH)
) (
  input  logic [WIDTH-1:0]     in_i,
  output logic [CNT_WIDTH-1:0] cnt_o,
  output logic                 empty_o
);

  // Depth of the tree, the leaf level pairs up the input bits
  localparam int unsigned num_levels = $clog2(WIDTH);
  // A full binary tree of this depth has one node fewer than this
  localparam int unsigned num_nodes  = 2 ** num_levels;

  // Input in scan order, bit 0 is looked at first
  logic [WIDTH-1:0] in_tmp;

  // Per node: does the subtree hold a one, and the index of its first one
  logic [num_nodes-2:0]                 sel_nodes;
  logic [num_nodes-2:0][num_levels-1:0] idx_nodes;

  // Leading mode reverses the vector so that the same tree counts from the MSB
  always_comb begin
    for (int unsigned i = 0; i < WIDTH; i++) begin
      if (MODE == LEADING_ZERO_CNT) begin
        in_tmp[i] = in_i[WIDTH-1-i];
      end else begin
        in_tmp[i] = in_i[i];
      end
    end
  end

  // Nodes are stored heap style, node k has its children at 2k+1 and 2k+2
  for (genvar lvl = 0; lvl < num_levels; lvl++) begin : g_level
    for (genvar n = 0; n < 2 ** lvl; n++) begin : g_node
      localparam int unsigned node = 2 ** lvl - 1 + n;

      if (lvl == num_levels - 1) begin : g_leaf
        // Leaves look directly at a pair of input bits
        if (2 * n + 1 < WIDTH) begin : g_pair
          assign sel_nodes[node] = in_tmp[2*n] | in_tmp[2*n+1];
          assign idx_nodes[node] = in_tmp[2*n] ? num_levels'(2 * n) :
                                                 num_levels'(2 * n + 1);
        end else if (2 * n < WIDTH) begin : g_single
          // Odd width leaves one bit without a partner
          assign sel_nodes[node] = in_tmp[2*n];
          assign idx_nodes[node] = num_levels'(2 * n);
        end else begin : g_unused
          // Past the end of the vector, never selected
          assign sel_nodes[node] = 1'b0;
          assign idx_nodes[node] = '0;
        end
      end else begin : g_inner
        localparam int unsigned left  = 2 * node + 1;
        localparam int unsigned right = 2 * node + 2;

        // The lower-index subtree wins whenever it holds a one
        assign sel_nodes[node] = sel_nodes[left] | sel_nodes[right];
        assign idx_nodes[node] = sel_nodes[left] ? idx_nodes[left] : idx_nodes[right];
      end
    end
  end

  // With no one present every node picks its right child, so the root
  // ends on the last index and the count reads as the largest value
  assign cnt_o   = CNT_WIDTH'(idx_nodes[0]);
  assign empty_o = ~sel_nodes[0];

endmodule

/* verilog/pipe_reg.sv */
/*
 * Pipeline register stage
 * Valid bit with reset plus a payload of any type, loaded only when valid
 */
`timescale 1ns/1ps

module pipe_reg #(
  // Payload type, a packed struct from the converter package
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic valid_i,
  input  T     data_i,
  output logic valid_o,
  output T     data_o
);

  // Valid follows the input one cycle later
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // Payload holds its last value while no valid data arrives
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      data_o <= data_i;
    end
  end

endmodule

/* verilog/i2f_scan.sv */
/*
 * Integer to float front stage
 * Splits off the sign, forms the magnitude and counts its leading and trailing zeros
 */
`timescale 1ns/1ps
`include "fp_params.svh"

module i2f_scan import lzc_pkg::*, fp_pkg::*; (
  input  logic [`I2F_INT_W-1:0] int_i,
  output scan_t                 scan_o
);

  logic                  sign;
  logic [`I2F_INT_W-1:0] magnitude;
  logic [`I2F_CNT_W-1:0] lead_cnt;
  logic [`I2F_CNT_W-1:0] trail_cnt;
  logic                  lead_empty;

  assign sign = int_i[`I2F_INT_W-1];

  // Two's complement negate, the most negative value wraps onto itself and
  // then reads correctly as 2^31 when taken as unsigned
  assign magnitude = sign ? (~int_i + 1'b1) : int_i;

  // Leading zeros give the shift that puts the top one at the MSB
  lzc #(
    .WIDTH    (`I2F_INT_W),
    .MODE     (LEADING_ZERO_CNT),
    .CNT_WIDTH(`I2F_CNT_W)
  ) lead_cnt_i (
    .in_i   (magnitude),
    .cnt_o  (lead_cnt),
    .empty_o(lead_empty)
  );

  // Trailing zeros locate the lowest one for the inexact check
  // Its empty flag would only repeat the one from the leading counter
  lzc #(
    .WIDTH    (`I2F_INT_W),
    .MODE     (TRAILING_ZERO_CNT),
    .CNT_WIDTH(`I2F_CNT_W)
  ) trail_cnt_i (
    .in_i   (magnitude),
    .cnt_o  (trail_cnt),
    .empty_o()
  );

  assign scan_o.sign      = sign;
  assign scan_o.magnitude = magnitude;
  assign scan_o.lead_cnt  = lead_cnt;
  assign scan_o.trail_cnt = trail_cnt;
  assign scan_o.zero      = lead_empty;

endmodule

/* verilog/i2f_pack.sv */
/*
 * Integer to float back stage
 * Normalizes the magnitude, builds exponent and truncated mantissa, flags dropped bits
 */
`timescale 1ns/1ps
`include "fp_params.svh"

module i2f_pack import fp_pkg::*; (
  input  scan_t scan_i,
  output pack_t pack_o
);

  // Exponent for a one in the MSB, that is bias plus 31
  localparam int unsigned top_exp = `I2F_EXP_BIAS + `I2F_INT_W - 1;
  // Bits below the mantissa after normalization, 8 for a 32-bit operand
  localparam int unsigned drop_w  = `I2F_INT_W - 1 - `I2F_MANT_W;

  logic [`I2F_INT_W-1:0]  shifted;
  logic [`I2F_EXP_W-1:0]  exponent;
  logic [`I2F_MANT_W-1:0] mantissa;
  logic                   inexact;

  // After the shift the leading one sits in the MSB and is the hidden bit
  assign shifted = scan_i.magnitude << scan_i.lead_cnt;

  // Truncation keeps the bits right under the hidden one
  assign mantissa = shifted[`I2F_INT_W-2 -: `I2F_MANT_W];

  // Each leading zero lowers the exponent by one
  assign exponent = `I2F_EXP_W'(top_exp - int'(scan_i.lead_cnt));

  // Only operands with fewer than 8 leading zeros lose any bits
  // The dropped field then covers magnitude bits 7-lead_cnt down to 0,
  // and a one lands there when the trailing count is below 8-lead_cnt
  always_comb begin
    inexact = 1'b0;
    if (!scan_i.zero && (int'(scan_i.lead_cnt) < drop_w)) begin
      inexact = int'(scan_i.trail_cnt) < (drop_w - int'(scan_i.lead_cnt));
    end
  end

  // Zero has no leading one, so the counters' values are meaningless
  // and the result is forced to positive zero
  always_comb begin
    if (scan_i.zero) begin
      pack_o.result.sign     = 1'b0;
      pack_o.result.exponent = '0;
      pack_o.result.mantissa = '0;
      pack_o.inexact         = 1'b0;
    end else begin
      pack_o.result.sign     = scan_i.sign;
      pack_o.result.exponent = exponent;
      pack_o.result.mantissa = mantissa;
      pack_o.inexact         = inexact;
    end
  end

endmodule

/* verilog/i2f_top.sv */
/*
 * Pipelined int32 to float32 converter
 * Scan, register, pack, register, one operand per cycle with a latency of two
 */
`timescale 1ns/1ps
`include "fp_params.svh"

module i2f_top import fp_pkg::*; (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  valid_i,
  input  logic [`I2F_INT_W-1:0] int_i,
  output logic                  valid_o,
  output fp32_t                 result_o,
  output logic                  inexact_o
);

  scan_t scan_d;
  scan_t scan_q;
  logic  scan_valid_q;
  pack_t pack_d;
  pack_t pack_q;

  // Sign, magnitude and zero counts of the incoming operand
  i2f_scan scan_i (
    .int_i (int_i),
    .scan_o(scan_d)
  );

  pipe_reg #(.T(scan_t)) scan_reg_i (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .valid_i (valid_i),
    .data_i  (scan_d),
    .valid_o (scan_valid_q),
    .data_o  (scan_q)
  );

  // Normalize and pack into the float32 fields
  i2f_pack pack_i (
    .scan_i(scan_q),
    .pack_o(pack_d)
  );

  pipe_reg #(.T(pack_t)) pack_reg_i (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .valid_i (scan_valid_q),
    .data_i  (pack_d),
    .valid_o (valid_o),
    .data_o  (pack_q)
  );

  assign result_o  = pack_q.result;
  assign inexact_o = pack_q.inexact;

endmodule

/* verification/i2f_tb.sv */
/*
 * Testbench for the pipelined int32 to float32 converter
 * Checks results and latency against a bit-level reference model
 */
`timescale 1ns/1ps
`include "fp_params.svh"

module i2f_tb import fp_pkg::*; ();

  localparam int clk_period   = 10;
  localparam int num_directed = 16;
  // One operand per power of two that a positive int32 can hold
  localparam int num_pow      = 31;
  localparam int num_wide     = 150;
  localparam int num_gap      = 150;
  localparam int num_tests    = num_directed + num_pow + num_wide + num_gap;
  // Each test gets 20 cycles on top of a fixed margin for reset and drain
  localparam int timeout_ns   = (num_tests * 20 + 1000) * clk_period;

  // Zero, small values, the 24-bit exact limit and its neighbours, and the
  // negative corners including the most negative integer
  localparam logic [31:0] directed_vals [num_directed] = '{
    32'h0000_0000, 32'h0000_0001, 32'h0000_0003, 32'h0000_0005,
    32'h0000_0007, 32'h0000_0064, 32'h0000_3039, 32'h00FF_FFFF,
    32'h0100_0000, 32'h0100_0001, 32'h7FFF_FFFF, 32'hFFFF_FFFF,
    32'hFFFF_FFFE, 32'h8000_0000, 32'hFFFF_FF9C, 32'hFF00_0001
  };

  logic        clk;
  logic        arst_n;
  logic        valid_in;
  logic [31:0] int_in;
  logic        valid_out;
  fp32_t       result_out;
  logic        inexact_out;

  // Expected results and their operands in input order
  pack_t       exp_q [$];
  logic [31:0] op_q [$];
  pack_t       exp_cur;
  logic [31:0] op_cur;
  int          sent;
  int          received;

  // Delayed copy of valid_in that marks the cycle where each result is due
  logic [1:0]  valid_hist;

  i2f_top uut (
    .clk_i    (clk),
    .arst_n_i (arst_n),
    .valid_i  (valid_in),
    .int_i    (int_in),
    .valid_o  (valid_out),
    .result_o (result_out),
    .inexact_o(inexact_out)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Reference conversion from the float32 rules. It locates the top one,
  // biases its position, keeps the next 23 bits and flags any one below them
  function automatic pack_t model_convert(input logic [31:0] value);
    pack_t       r;
    logic [31:0] mag;
    int          top;
    r   = '0;
    top = 0;
    if (value != 32'd0) begin
      mag = value[31] ? (~value + 32'd1) : value;
      for (int i = 0; i < 32; i++) begin
        if (mag[i]) begin
          top = i;
        end
      end
      r.result.sign     = value[31];
      r.result.exponent = 8'(`I2F_EXP_BIAS + top);
      if (top > `I2F_MANT_W) begin
        // For a wide magnitude the leading one lands on bit 23 and drops off
        r.result.mantissa = 23'(mag >> (top - `I2F_MANT_W));
        r.inexact = |(mag & ((32'd1 << (top - `I2F_MANT_W)) - 32'd1));
      end else begin
        r.result.mantissa = 23'(mag << (`I2F_MANT_W - top));
        r.inexact = 1'b0;
      end
    end
    return r;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
    $display("CHECK FAILED at %0t ns: %s = %h, expected %h (operand %h)",
             $time, name, got, want, op_cur);
    $display("TEST RESULT: FAIL");
    $fatal(1, "value mismatch");
  endtask

  // Drives one valid operand on the next rising edge and queues its expected result
  task automatic send_operand(input logic [31:0] value);
    @(posedge clk);
    valid_in <= 1'b1;
    int_in   <= value;
    exp_q.push_back(model_convert(value));
    op_q.push_back(value);
    sent++;
  endtask

  // Invalid cycle with junk data that the pipeline must ignore
  task automatic idle_cycle();
    @(posedge clk);
    valid_in <= 1'b0;
    int_in   <= $urandom();
  endtask

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_hist <= 2'b00;
    end else begin
      valid_hist <= {valid_hist[0], valid_in};
    end
  end

  // Every valid_o pulse lines up with a valid_i two edges earlier
  valid_latency_a: assert property (
    @(posedge clk) disable iff (!arst_n) valid_out == valid_hist[1]
  ) else begin
    $display("CHECK FAILED at %0t ns: valid_o = %b, expected %b",
             $time, $sampled(valid_out), $sampled(valid_hist[1]));
    $display("TEST RESULT: FAIL");
    $fatal(1, "latency mismatch");
  end

  // No result may leave while reset is held
  reset_idle_a: assert property (
    @(posedge clk) !arst_n |-> !valid_out
  ) else begin
    $display("CHECK FAILED at %0t ns: valid_o = %b during reset, expected 0",
             $time, $sampled(valid_out));
    $display("TEST RESULT: FAIL");
    $fatal(1, "valid during reset");
  end

  // Outputs are compared mid-cycle away from the driving edge
  always @(negedge clk) begin
    if (arst_n && valid_out) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected result at %0t ns: valid_o high with no operand pending",
                 $time);
        $display("TEST RESULT: FAIL");
        $fatal(1, "extra result");
      end else begin
        exp_cur = exp_q.pop_front();
        op_cur  = op_q.pop_front();
        received++;
        assert (result_out == exp_cur.result)
          else report_mismatch("result_o", result_out, exp_cur.result);
        assert (inexact_out == exp_cur.inexact)
          else report_mismatch("inexact_o", 32'(inexact_out), 32'(exp_cur.inexact));
      end
    end
  end

  initial begin
    #(timeout_ns);
    $display("Timeout after %0d ns: %0d of %0d results arrived", timeout_ns,
             received, sent);
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    logic [31:0] mag;
    logic [31:0] value;
    void'($urandom(32'h595e2d4c));
    arst_n   = 1'b0;
    valid_in = 1'b0;
    int_in   = '0;
    sent     = 0;
    received = 0;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;

    // valid_o has to stay low through a quiet stretch after reset
    repeat (8) idle_cycle();

    // Directed corners go back to back with zero first for the empty count path
    foreach (directed_vals[i]) begin
      send_operand(directed_vals[i]);
    end
    idle_cycle();

    // Powers of two convert exactly
    for (int k = 0; k < num_pow; k++) begin
      send_operand(32'd1 << k);
    end
    repeat (3) idle_cycle();

    // Magnitudes of 25 to 31 significant bits get truncated
    for (int n = 0; n < num_wide; n++) begin
      mag   = {1'b0, 31'($urandom())} | 32'h0100_0000;
      value = ($urandom() & 1) ? (~mag + 32'd1) : mag;
      send_operand(value);
    end
    idle_cycle();

    // Full range operands with random gaps between them
    for (int n = 0; n < num_gap; n++) begin
      send_operand($urandom());
      repeat ($urandom_range(0, 3)) idle_cycle();
    end
    idle_cycle();

    // Each result is due two cycles after its operand, so a few more cycles
    // drain the pipeline and give a late duplicate time to show up
    repeat (4) @(negedge clk);

    if (received != sent) begin
      $display("Result count wrong: %0d operands sent, %0d results received",
               sent, received);
      $display("TEST RESULT: FAIL");
      $fatal(1, "lost or duplicated results");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

/* tb.f */
+incdir+verilog
verilog/lzc_pkg.sv
verilog/fp_pkg.sv
verilog/lzc.sv
verilog/pipe_reg.sv
verilog/i2f_scan.sv
verilog/i2f_pack.sv
verilog/i2f_top.sv
verification/i2f_tb.sv

/* Makefile */
# Verilator build and run for the int32 to float32 converter

TOP := i2f_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

lint:
	verilator --lint-only -Wall --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir
